// ==== mips_lsu.f ====
source/lsu_isa_pkg.sv
source/lsu_pipe_pkg.sv
source/stage_reg.sv
source/exe_agu.sv
source/mem_stage.sv
source/wb_commit.sv
source/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

// ==== Makefile ====
TOP := lsu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f mips_lsu.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb;

    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;

    localparam int MAX_ENTRIES = 64;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    mem_cmd_t    issue;
    logic        issue_allowin;
    sram_req_t   sram_req;
    logic [31:0] sram_rdata;
    logic        commit_ready;
    rf_write_t   rf_write;

    string       tbl_name [MAX_ENTRIES];
    mem_cmd_t    tbl_cmd  [MAX_ENTRIES];
    logic [31:0] tbl_exp  [MAX_ENTRIES];   // expected write-back value
    logic [31:0] tbl_addr [MAX_ENTRIES];   // expected physical address
    logic        tbl_we   [MAX_ENTRIES];
    int          tbl_n;

    logic [31:0] mem_img [256];
    logic [31:0] reg_img [32];
    logic [31:0] ram     [256];
    logic [7:0]  ram_idx;

    int          cyc;
    int          limit;
    int          xfer_count;
    int          commit_count;
    int          expect_commits;
    int          cur_idx;
    int          pend_idx [$];
    int          pend_cyc [$];
    logic        pend_strict [$];
    logic        rand_ready;
    logic        saw_stall;
    integer      seed;

    lsu_top u_lsu_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_allowin (issue_allowin),
        .sram_req      (sram_req),
        .sram_rdata    (sram_rdata),
        .commit_ready  (commit_ready),
        .rf_write      (rf_write)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // ram model, read data held between accesses
    // ------------------------------
    assign ram_idx = sram_req.addr[9:2];

    always @(posedge clk) begin
        if (sram_req.en) begin
            for (int b = 0; b < 4; b++) begin
                if (sram_req.wen[b]) ram[ram_idx][8*b +: 8] <= sram_req.wdata[8*b +: 8];
            end
            sram_rdata <= ram[ram_idx];
        end
    end

    always begin
        int r;
        @(posedge clk);
        #1;
        if (rand_ready) begin
            r = $random(seed);
            commit_ready = r[0];
        end else begin
            commit_ready = 1'b1;
        end
    end

    function automatic logic [31:0] fill_word(input logic [7:0] i);
        return {i, ~i, i ^ 8'h5a, i + 8'h37};   // differs in every address bit
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // ------------------------------
    // reference model over the images
    // ------------------------------
    task automatic model_apply(input mem_cmd_t c, output logic [31:0] v, output logic we,
                               output logic [31:0] pa);
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  idx;
        int          b;
        pa  = (c.base + {{16{c.offset[15]}}, c.offset}) & 32'h1fff_ffff;
        idx = pa[9:2];
        b   = int'(pa[1:0]);
        w   = mem_img[idx];
        h   = w[16*(b/2) +: 16];
        v   = 32'h0;
        we  = 1'b1;
        case (c.op)
            OP_PASS: v = c.base;
            OP_LW:   v = w;
            OP_LH:   v = {{16{h[15]}}, h};
            OP_LHU:  v = {16'h0, h};
            OP_LB:   v = {{24{w[8*b+7]}}, w[8*b +: 8]};
            OP_LBU:  v = {24'h0, w[8*b +: 8]};
            OP_LWL: begin
                v = reg_img[c.dest];
                for (int i = 0; i <= b; i++) begin
                    v[8*(3-b+i) +: 8] = w[8*i +: 8];   // bytes 0..b on top
                end
            end
            OP_LWR: begin
                v = reg_img[c.dest];
                for (int i = b; i < 4; i++) begin
                    v[8*(i-b) +: 8] = w[8*i +: 8];     // bytes b..3 at bottom
                end
            end
            OP_SW: begin
                mem_img[idx] = c.store_data;
                we = 1'b0;
            end
            OP_SH: begin
                mem_img[idx][16*(b/2) +: 16] = c.store_data[15:0];
                we = 1'b0;
            end
            OP_SB: begin
                mem_img[idx][8*b +: 8] = c.store_data[7:0];
                we = 1'b0;
            end
            default: we = 1'b0;
        endcase
        if (we && c.dest != 5'd0) reg_img[c.dest] = v;
    endtask

    task automatic add(input string nm, input mem_op_t op, input logic [31:0] base,
                       input logic [15:0] off, input logic [31:0] sd, input logic [4:0] dest);
        mem_cmd_t c;
        c.op         = op;
        c.base       = base;
        c.offset     = off;
        c.store_data = sd;
        c.dest       = dest;
        tbl_name[tbl_n] = nm;
        tbl_cmd[tbl_n]  = c;
        model_apply(c, tbl_exp[tbl_n], tbl_we[tbl_n], tbl_addr[tbl_n]);
        tbl_n++;
    endtask

    task automatic run_pass();
        int target;
        for (int e = 0; e < tbl_n; e++) begin
            cur_idx     = e;
            issue       = tbl_cmd[e];
            issue_valid = 1'b1;
            target      = xfer_count + 1;
            do begin
                @(posedge clk);
                #1;
            end while (xfer_count != target);
        end
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pend_idx.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ------------------------------
    // monitor, sampled at the rising edge
    // ------------------------------
    always @(posedge clk) begin
        int   i;
        int   c;
        logic s;
        cyc = cyc + 1;
        if (cyc > limit) begin
            $display("timeout after %0d cycles, %0d commits still pending", cyc, pend_idx.size());
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
        if (rst_n) begin
            if (issue_valid && !issue_allowin) saw_stall = 1'b1;
            if (sram_req.en) begin
                check({tbl_name[cur_idx], " addr"}, tbl_addr[cur_idx], sram_req.addr);
            end
            if (rf_write.we) begin
                if (pend_idx.size() == 0) begin
                    $display("register write seen with no load or pass in flight");
                    $display("TESTS FAILED");
                    $fatal(1, "spurious commit");
                end
                i = pend_idx.pop_front();
                c = pend_cyc.pop_front();
                s = pend_strict.pop_front();
                commit_count++;
                check(tbl_name[i], tbl_exp[i], rf_write.wdata);
                check({tbl_name[i], " dest"}, 32'(tbl_cmd[i].dest), 32'(rf_write.wnum));
                if (s) check({tbl_name[i], " latency"}, 32'd2, 32'(cyc - c));
            end
            if (issue_valid && issue_allowin) begin
                if (tbl_we[cur_idx]) begin
                    pend_idx.push_back(cur_idx);
                    pend_cyc.push_back(cyc);
                    pend_strict.push_back(!rand_ready);   // latency only fixed with ready high
                end
                xfer_count++;
            end
        end
    end

    initial begin
        seed         = 32'h3a73;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        commit_ready = 1'b0;
        sram_rdata   = 32'h0;
        rand_ready   = 1'b0;
        saw_stall    = 1'b0;
        cyc          = 0;
        xfer_count   = 0;
        commit_count = 0;
        cur_idx      = 0;
        tbl_n        = 0;
        limit        = 100000;
        for (int i = 0; i < 256; i++) begin
            mem_img[i] = fill_word(8'(i));
            ram[i]     = fill_word(8'(i));
        end
        for (int i = 0; i < 32; i++) reg_img[i] = 32'h0;

        // stores of every width, read back
        add("sw word", OP_SW, 32'h40, 16'h0, 32'hcafe_f00d, 5'd0);
        add("lw after sw", OP_LW, 32'h40, 16'h0, 32'h0, 5'd1);
        for (int k = 0; k < 2; k++) begin
            add($sformatf("sh +%0d", 2*k), OP_SH, 32'h44, 16'(2*k), 32'h1234_5678 + 32'(k), 5'd0);
        end
        add("lw after sh", OP_LW, 32'h44, 16'h0, 32'h0, 5'd2);
        for (int k = 0; k < 4; k++) begin
            add($sformatf("sb +%0d", k), OP_SB, 32'h48, 16'(k), 32'hffff_ff3c + 32'(7*k), 5'd0);
        end
        add("lw after sb", OP_LW, 32'h48, 16'h0, 32'h0, 5'd3);

        // sub-word loads of a known word, negative offsets
        add("sw known", OP_SW, 32'h50, 16'h0, 32'h8a7f_c3e5, 5'd0);
        for (int k = 0; k < 4; k++) begin
            add($sformatf("lb +%0d", k), OP_LB, 32'h54, 16'(k - 4), 32'h0, 5'(4 + k));
            add($sformatf("lbu +%0d", k), OP_LBU, 32'h54, 16'(k - 4), 32'h0, 5'(4 + k));
        end
        for (int k = 0; k < 2; k++) begin
            add($sformatf("lh +%0d", 2*k), OP_LH, 32'h54, 16'(2*k - 4), 32'h0, 5'd8);
            add($sformatf("lhu +%0d", 2*k), OP_LHU, 32'h54, 16'(2*k - 4), 32'h0, 5'd9);
        end

        // unaligned merges into a preset register
        add("sw merge src", OP_SW, 32'h60, 16'h0, 32'h1122_3344, 5'd0);
        for (int k = 0; k < 4; k++) begin
            add($sformatf("pass r%0d", 10 + k), OP_PASS, 32'ha5a5_5a5a, 16'h0, 32'h0, 5'(10 + k));
            add($sformatf("lwl +%0d", k), OP_LWL, 32'h60, 16'(k), 32'h0, 5'(10 + k));
            add($sformatf("pass r%0d", 14 + k), OP_PASS, 32'h0f0f_f0f0, 16'h0, 32'h0, 5'(14 + k));
            add($sformatf("lwr +%0d", k), OP_LWR, 32'h60, 16'(k), 32'h0, 5'(14 + k));
        end

        // kseg0 and kseg1 fold, then r0
        add("sw kseg0", OP_SW, 32'h8000_0100, 16'h0, 32'h0bad_f00d, 5'd0);
        add("lw kseg1", OP_LW, 32'ha000_0100, 16'h0, 32'h0, 5'd20);
        add("sb kseg1", OP_SB, 32'ha000_0105, 16'h0, 32'h0000_0077, 5'd0);
        add("lw kseg0", OP_LW, 32'h8000_0104, 16'h0, 32'h0, 5'd21);
        add("pass r0", OP_PASS, 32'hdead_beef, 16'h0, 32'h0, 5'd0);
        add("lwl r0", OP_LWL, 32'h60, 16'h1, 32'h0, 5'd0);

        expect_commits = 0;
        for (int i = 0; i < tbl_n; i++) if (tbl_we[i]) expect_commits += 2;   // two passes
        limit = tbl_n * 8 + 50;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_pass();
        wait_drain();
        @(posedge clk);
        rand_ready = 1'b1;   // random back-pressure from here on
        #1;
        run_pass();
        wait_drain();

        check("commit count", 32'(expect_commits), 32'(commit_count));
        if (!saw_stall) begin
            $display("issue_allowin never fell while both stages were full");
            $display("TESTS FAILED");
            $fatal(1, "no back-pressure seen");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== sim/lsu_checker.sv ====
`timescale 1ns/1ns

module lsu_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    mem_valid,
    input logic                    commit_ready,
    input logic                    wb_allowin,
    input lsu_pipe_pkg::sram_req_t sram_req,
    input lsu_pipe_pkg::rf_write_t rf_write
);

    // no new access while the memory stage holds an entry that cannot leave
    a_no_stalled_access: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && !wb_allowin) |-> !sram_req.en)
        else $error("ram access issued while the memory stage is stalled");

    a_quiet_reset: assert property (@(posedge clk)
        !rst_n |-> !rf_write.we)
        else $error("register write during reset");

    // wb full and blocked, so its payload must not move
    a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!commit_ready && !wb_allowin) |=> ($stable(rf_write.wnum) && $stable(rf_write.wdata)))
        else $error("held writeback payload changed under back-pressure");

endmodule

bind lsu_top lsu_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_valid     (to_wb_valid),
    .commit_ready  (commit_ready),
    .wb_allowin    (wb_allowin),
    .sram_req      (sram_req),
    .rf_write      (rf_write)
);

// ==== source/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue_valid,
    input  lsu_pipe_pkg::mem_cmd_t  issue,
    output logic                    issue_allowin,
    output lsu_pipe_pkg::sram_req_t sram_req,
    input  logic [31:0]             sram_rdata,
    input  logic                    commit_ready,
    output lsu_pipe_pkg::rf_write_t rf_write
);

    import lsu_pipe_pkg::*;

    // ------------------------------
    // stage boundaries
    // ------------------------------
    logic        to_mem_valid;
    exe_to_mem_t to_mem;
    logic        mem_allowin;
    logic        to_wb_valid;
    mem_to_wb_t  to_wb;
    logic        wb_allowin;

    exe_agu u_exe (
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_allowin (issue_allowin),
        .mem_allowin   (mem_allowin),
        .to_mem_valid  (to_mem_valid),
        .to_mem        (to_mem),
        .sram_req      (sram_req)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (to_mem_valid),
        .in_cmd     (to_mem),
        .in_allowin (mem_allowin),
        .sram_rdata (sram_rdata),
        .out_valid  (to_wb_valid),
        .out_data   (to_wb),
        .wb_allowin (wb_allowin)
    );

    wb_commit u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (to_wb_valid),
        .in_data      (to_wb),
        .in_allowin   (wb_allowin),
        .commit_ready (commit_ready),
        .rf_write     (rf_write)
    );

endmodule

// ==== source/wb_commit.sv ====
`timescale 1ns/1ns

module wb_commit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  lsu_pipe_pkg::mem_to_wb_t in_data,
    output logic                     in_allowin,
    input  logic                     commit_ready,
    output lsu_pipe_pkg::rf_write_t  rf_write
);

    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;

    mem_to_wb_t  held;
    logic        held_valid;
    logic [31:0] regs [32];
    logic [31:0] old_value;    // current register content for lwl/lwr
    logic [31:0] shifted;
    logic [31:0] lane_mask;
    logic [31:0] result;
    logic [4:0]  shamt;

    stage_reg #(
        .payload_t (mem_to_wb_t)
    ) u_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_payload  (in_data),
        .in_allowin  (in_allowin),
        .out_valid   (held_valid),
        .out_payload (held),
        .out_allowin (commit_ready)
    );

    assign old_value = (held.dest == '0) ? 32'h0 : regs[held.dest];
    assign shamt     = {held.addr_low, 3'b000};
    assign lane_mask = {{8{held.merge_mask[3]}}, {8{held.merge_mask[2]}},
                        {8{held.merge_mask[1]}}, {8{held.merge_mask[0]}}};

    // ------------------------------
    // load alignment
    // ------------------------------
    always_comb begin
        shifted = held.data >> shamt;   // addressed byte to lane 0
        result  = held.data;
        case (held.op)
            OP_LB:  result = {{24{shifted[7]}}, shifted[7:0]};
            OP_LBU: result = {24'h0, shifted[7:0]};
            OP_LH:  result = {{16{shifted[15]}}, shifted[15:0]};
            OP_LHU: result = {16'h0, shifted[15:0]};
            OP_LWL: begin
                shifted = held.data << (5'd24 - shamt);   // low bytes up to the top
                result  = (shifted & lane_mask) | (old_value & ~lane_mask);
            end
            OP_LWR: begin
                result = (shifted & lane_mask) | (old_value & ~lane_mask);
            end
            default: result = held.data;   // lw and pass
        endcase
    end

    // ------------------------------
    // commit
    // ------------------------------
    always_comb begin
        rf_write.we    = held_valid && commit_ready && writes_rf(held.op);
        rf_write.wnum  = held.dest;
        rf_write.wdata = result;
    end

    // r0 stays zero
    always_ff @(posedge clk) begin
        if (rf_write.we && rf_write.wnum != '0) begin
            regs[rf_write.wnum] <= rf_write.wdata;
        end
    end

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  lsu_pipe_pkg::exe_to_mem_t in_cmd,
    output logic                      in_allowin,
    input  logic [31:0]               sram_rdata,
    output logic                      out_valid,
    output lsu_pipe_pkg::mem_to_wb_t  out_data,
    input  logic                      wb_allowin
);

    import lsu_isa_pkg::*;
    import lsu_pipe_pkg::*;

    exe_to_mem_t held;
    logic [3:0]  merge_mask;

    stage_reg #(
        .payload_t (exe_to_mem_t)
    ) u_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_payload  (in_cmd),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_payload (held),
        .out_allowin (wb_allowin)
    );

    // ------------------------------
    // lwl/lwr byte merge, little endian
    // ------------------------------
    always_comb begin
        merge_mask = 4'b1111;
        if (held.op == OP_LWL) begin
            merge_mask = 4'b1111 << (3 - held.addr_low);   // high bytes of the register
        end else if (held.op == OP_LWR) begin
            merge_mask = 4'b1111 >> held.addr_low;         // low bytes of the register
        end
    end

    // ram data is stable while this stage is occupied
    always_comb begin
        out_data.op         = held.op;
        out_data.addr_low   = held.addr_low;
        out_data.data       = is_load(held.op) ? sram_rdata : held.pass_value;
        out_data.merge_mask = merge_mask;
        out_data.dest       = held.dest;
    end

endmodule

// ==== source/exe_agu.sv ====
`timescale 1ns/1ns

module exe_agu (
    input  logic                    issue_valid,
    input  lsu_pipe_pkg::mem_cmd_t  issue,
    output logic                    issue_allowin,
    input  logic                    mem_allowin,
    output logic                    to_mem_valid,
    output lsu_pipe_pkg::exe_to_mem_t to_mem,
    output lsu_pipe_pkg::sram_req_t sram_req
);

    import lsu_isa_pkg::*;

    logic [31:0] vaddr;
    logic [31:0] paddr;
    logic        fire;       // transfer into mem this cycle
    logic        touches_ram;
    logic [3:0]  st_wen;
    logic [31:0] st_wdata;

    // ------------------------------
    // address generation
    // ------------------------------
    assign vaddr = issue.base + {{16{issue.offset[15]}}, issue.offset};
    assign paddr = {{PHYS_MASK_BITS{1'b0}}, vaddr[31-PHYS_MASK_BITS:0]};   // fixed mapping

    // nothing held here, so exe accepts whenever mem does
    assign issue_allowin = mem_allowin;
    assign fire          = issue_valid && mem_allowin;
    assign touches_ram   = is_load(issue.op) || is_store(issue.op);

    // ------------------------------
    // store lanes
    // ------------------------------
    always_comb begin
        st_wen   = 4'b0000;
        st_wdata = issue.store_data;
        case (issue.op)
            OP_SW: begin
                st_wen = 4'b1111;
            end
            OP_SH: begin
                st_wen   = paddr[1] ? 4'b1100 : 4'b0011;   // upper or lower half
                st_wdata = {2{issue.store_data[15:0]}};
            end
            OP_SB: begin
                st_wen   = 4'b0001 << paddr[1:0];
                st_wdata = {4{issue.store_data[7:0]}};
            end
            default: begin
                st_wen = 4'b0000;   // loads read with no lanes
            end
        endcase
    end

    // ------------------------------
    // ram request, only when the access cannot stall
    // ------------------------------
    always_comb begin
        sram_req.en    = fire && touches_ram;
        sram_req.wen   = (fire && is_store(issue.op)) ? st_wen : 4'b0000;
        sram_req.addr  = paddr;
        sram_req.wdata = st_wdata;
    end

    // payload for the memory stage
    always_comb begin
        to_mem_valid        = issue_valid;
        to_mem.op           = issue.op;
        to_mem.addr_low     = paddr[1:0];
        to_mem.pass_value   = issue.base;   // pass ops skip the ram
        to_mem.dest         = issue.dest;
    end

endmodule

// ==== source/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_allowin
);

    logic     valid_q;
    payload_t payload_q;

    // empty, or the held entry leaves this cycle
    assign in_allowin = !valid_q || out_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            payload_q <= '0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
            if (in_valid) begin
                payload_q <= in_payload;   // load only on a transfer
            end
        end
    end

    assign out_valid   = valid_q;
    assign out_payload = payload_q;

endmodule

// ==== source/lsu_pipe_pkg.sv ====
package lsu_pipe_pkg;

    // ------------------------------
    // stage payloads
    // ------------------------------
    typedef struct packed {
        lsu_isa_pkg::mem_op_t                      op;
        logic [31:0]                               base;
        logic [15:0]                               offset;     // sign-extended in exe
        logic [31:0]                               store_data;
        logic [lsu_isa_pkg::REG_NUM_W-1:0]         dest;
    } mem_cmd_t;

    typedef struct packed {
        lsu_isa_pkg::mem_op_t                      op;
        logic [1:0]                                addr_low;
        logic [31:0]                               pass_value;
        logic [lsu_isa_pkg::REG_NUM_W-1:0]         dest;
    } exe_to_mem_t;

    typedef struct packed {
        lsu_isa_pkg::mem_op_t                      op;
        logic [1:0]                                addr_low;
        logic [31:0]                               data;       // raw ram word or pass value
        logic [3:0]                                merge_mask; // bytes taken from data
        logic [lsu_isa_pkg::REG_NUM_W-1:0]         dest;
    } mem_to_wb_t;

    // ------------------------------
    // external ports
    // ------------------------------
    typedef struct packed {
        logic        en;
        logic [3:0]  wen;   // byte lanes, 0 on reads
        logic [31:0] addr;  // physical byte address
        logic [31:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic                              we;
        logic [lsu_isa_pkg::REG_NUM_W-1:0] wnum;
        logic [31:0]                       wdata;
    } rf_write_t;

endpackage

// ==== source/lsu_isa_pkg.sv ====
package lsu_isa_pkg;

    // ------------------------------
    // operation encodings
    // ------------------------------
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,   // bubble, no effect
        OP_PASS = 4'd1,   // writes base straight through
        OP_LW   = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LB   = 4'd5,
        OP_LBU  = 4'd6,
        OP_LWL  = 4'd7,   // unaligned left part
        OP_LWR  = 4'd8,   // unaligned right part
        OP_SW   = 4'd9,
        OP_SH   = 4'd10,
        OP_SB   = 4'd11
    } mem_op_t;

    // ------------------------------
    // address map and sizes
    // ------------------------------
    localparam int PHYS_MASK_BITS = 3;   // kseg0/kseg1 fold
    localparam int REG_NUM_W      = 5;   // 32 registers

    function automatic logic is_load(input mem_op_t op);
        return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_LWL, OP_LWR};
    endfunction

    function automatic logic is_store(input mem_op_t op);
        return op inside {OP_SW, OP_SH, OP_SB};
    endfunction

    function automatic logic writes_rf(input mem_op_t op);
        return is_load(op) || (op == OP_PASS);
    endfunction

endpackage
